// File: include/spi_minion_cfg.svh
`ifndef SPI_MINION_CFG_SVH
`define SPI_MINION_CFG_SVH

// Width of one payload word carried in a frame.
`define SPI_DATA_BITS 32

// Entries in each message queue, two or more.
`define SPI_QUEUE_DEPTH 8

// Write flag and read flag sit above the payload.
`define SPI_FRAME_BITS (`SPI_DATA_BITS + 2)

`endif

// File: list.f
+incdir+include
logic/spi_minion_pkg.sv
logic/spi_pin_sync.sv
logic/spi_shifter.sv
logic/msg_queue.sv
logic/minion_adapter.sv
logic/spi_minion.sv
verification/spi_minion_checker.sv
verification/spi_minion_tb.sv

// File: logic/minion_adapter.sv
`timescale 1ns/10ps

module minion_adapter
	import spi_minion_pkg::*;
(
	input  logic   pull_en,
	input  logic   push_en,
	input  frame_t push_frame,
	input  logic   wq_enq_rdy,
	input  count_t wq_num_free,
	input  logic   rq_deq_val,
	input  data_t  rq_deq_msg,
	input  data_t  send_msg,
	input  logic   send_val,
	output logic   wq_enq_val,
	output logic   rq_deq_rdy,
	output frame_t pull_frame,
	output logic   adapter_parity
);

	localparam int frame_bits = $bits(frame_t);
	localparam int data_bits = $bits(data_t);

	logic write_flag;
	logic read_flag;
	logic dequeued;
	logic space;
	data_t reply_data;

	assign write_flag = push_frame[frame_bits - 1];
	assign read_flag = push_frame[frame_bits - 2];

	// A closing frame with the write flag offers its data to the write queue.
	assign wq_enq_val = push_en && write_flag;

	// A read request is served at the start of the following frame.
	assign rq_deq_rdy = pull_en && read_flag;
	assign dequeued = rq_deq_rdy && rq_deq_val;

	// Room remains after any enqueue taken in the same cycle.
	assign space = wq_enq_rdy && (!wq_enq_val || (wq_num_free > count_t'(1)));

	// No stale queue contents leak into an empty reply.
	assign reply_data = rq_deq_msg & {data_bits{dequeued}};

	assign pull_frame = {dequeued, space, reply_data};

	assign adapter_parity = (^send_msg) && send_val;

endmodule

// File: logic/msg_queue.sv
`timescale 1ns/10ps

`include "spi_minion_cfg.svh"

module msg_queue
	import spi_minion_pkg::*;
#(
	parameter int depth = `SPI_QUEUE_DEPTH
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   enq_val,
	input  data_t  enq_msg,
	input  logic   deq_rdy,
	output logic   enq_rdy,
	output logic   deq_val,
	output data_t  deq_msg,
	output count_t num_free
);

	localparam int ptr_bits = $clog2(depth);
	localparam logic [ptr_bits - 1:0] last_entry = ptr_bits'(depth - 1);

	data_t storage [depth];

	logic [ptr_bits - 1:0] enq_ptr;
	logic [ptr_bits - 1:0] deq_ptr;
	logic [ptr_bits - 1:0] enq_ptr_inc;
	logic [ptr_bits - 1:0] deq_ptr_inc;
	logic full;
	logic empty;
	logic do_enq;
	logic do_deq;

	// Equal pointers mean empty unless the full flag is set.
	assign empty = !full && (enq_ptr == deq_ptr);

	assign enq_rdy = !full;
	assign deq_val = !empty;

	assign do_enq = enq_val && enq_rdy;
	assign do_deq = deq_rdy && deq_val;

	// Pointers wrap at depth, which need not be a power of two.
	assign enq_ptr_inc = (enq_ptr == last_entry) ? '0 : enq_ptr + 1'b1;
	assign deq_ptr_inc = (deq_ptr == last_entry) ? '0 : deq_ptr + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			enq_ptr <= '0;
			deq_ptr <= '0;
			full <= 1'b0;
		end else begin
			if (do_enq) begin
				enq_ptr <= enq_ptr_inc;
			end
			if (do_deq) begin
				deq_ptr <= deq_ptr_inc;
			end
			if (do_enq && !do_deq && (enq_ptr_inc == deq_ptr)) begin
				full <= 1'b1;
			end else if (do_deq && !do_enq) begin
				full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_enq) begin
			storage[enq_ptr] <= enq_msg;
		end
	end

	// The head entry is read straight from storage.
	assign deq_msg = storage[deq_ptr];

	always_comb begin
		if (full) begin
			num_free = '0;
		end else if (enq_ptr >= deq_ptr) begin
			num_free = count_t'(depth - (enq_ptr - deq_ptr));
		end else begin
			num_free = count_t'(deq_ptr - enq_ptr);
		end
	end

	// A full queue has its tail wrapped round onto its head.
	full_pointers_meet: assert property (
		@(posedge clk) disable iff (reset) full |-> (enq_ptr == deq_ptr)
	);

	// The free count follows every enqueue and dequeue.
	free_count_tracks: assert property (
		@(posedge clk) disable iff (reset)
		1'b1 |=> (num_free == count_t'($past(num_free) + $past(do_deq) - $past(do_enq)))
	);

endmodule

// File: logic/spi_minion.sv
`timescale 1ns/10ps

`include "spi_minion_cfg.svh"

module spi_minion
	import spi_minion_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  cs,
	input  logic  sclk,
	input  logic  mosi,
	input  data_t recv_msg,
	input  logic  recv_val,
	input  logic  send_rdy,
	output logic  miso,
	output logic  recv_rdy,
	output logic  send_val,
	output logic  minion_parity,
	output logic  adapter_parity,
	output data_t send_msg
);

	logic cs_level;
	logic cs_rise;
	logic cs_fall;
	logic sclk_rise;
	logic sclk_fall;
	logic mosi_level;

	logic pull_en;
	logic push_en;
	frame_t push_frame;
	frame_t pull_frame;

	logic wq_enq_val;
	logic wq_enq_rdy;
	count_t wq_num_free;
	logic rq_deq_val;
	logic rq_deq_rdy;
	data_t rq_deq_msg;

	// Chip select idles high.
	spi_pin_sync #(
		.reset_value(1'b1)
	) cs_sync (
		.clk(clk),
		.reset(reset),
		.pin(cs),
		.sync_level(cs_level),
		.rise(cs_rise),
		.fall(cs_fall)
	);

	spi_pin_sync #(
		.reset_value(1'b0)
	) sclk_sync (
		.clk(clk),
		.reset(reset),
		.pin(sclk),
		.sync_level(),
		.rise(sclk_rise),
		.fall(sclk_fall)
	);

	spi_pin_sync #(
		.reset_value(1'b0)
	) mosi_sync (
		.clk(clk),
		.reset(reset),
		.pin(mosi),
		.sync_level(mosi_level),
		.rise(),
		.fall()
	);

	spi_shifter shifter (
		.clk(clk),
		.reset(reset),
		.cs_level(cs_level),
		.cs_rise(cs_rise),
		.cs_fall(cs_fall),
		.sclk_rise(sclk_rise),
		.sclk_fall(sclk_fall),
		.mosi_level(mosi_level),
		.pull_frame(pull_frame),
		.miso(miso),
		.pull_en(pull_en),
		.push_en(push_en),
		.frame_parity(minion_parity),
		.push_frame(push_frame)
	);

	minion_adapter adapter (
		.pull_en(pull_en),
		.push_en(push_en),
		.push_frame(push_frame),
		.wq_enq_rdy(wq_enq_rdy),
		.wq_num_free(wq_num_free),
		.rq_deq_val(rq_deq_val),
		.rq_deq_msg(rq_deq_msg),
		.send_msg(send_msg),
		.send_val(send_val),
		.wq_enq_val(wq_enq_val),
		.rq_deq_rdy(rq_deq_rdy),
		.pull_frame(pull_frame),
		.adapter_parity(adapter_parity)
	);

	// Host to system.
	msg_queue #(
		.depth(`SPI_QUEUE_DEPTH)
	) write_queue (
		.clk(clk),
		.reset(reset),
		.enq_val(wq_enq_val),
		.enq_msg(push_frame[`SPI_DATA_BITS - 1:0]),
		.deq_rdy(send_rdy),
		.enq_rdy(wq_enq_rdy),
		.deq_val(send_val),
		.deq_msg(send_msg),
		.num_free(wq_num_free)
	);

	// System to host.
	msg_queue #(
		.depth(`SPI_QUEUE_DEPTH)
	) read_queue (
		.clk(clk),
		.reset(reset),
		.enq_val(recv_val),
		.enq_msg(recv_msg),
		.deq_rdy(rq_deq_rdy),
		.enq_rdy(recv_rdy),
		.deq_val(rq_deq_val),
		.deq_msg(rq_deq_msg),
		.num_free()
	);

endmodule

// File: logic/spi_minion_pkg.sv
`include "spi_minion_cfg.svh"

package spi_minion_pkg;

	// One payload word.
	typedef logic [`SPI_DATA_BITS - 1:0] data_t;

	// One serial frame.
	// Outbound the top bits are {write, read}, inbound they are {valid, space}.
	typedef logic [`SPI_FRAME_BITS - 1:0] frame_t;

	// Free-entry count, able to hold the full queue depth.
	typedef logic [$clog2(`SPI_QUEUE_DEPTH + 1) - 1:0] count_t;

endpackage

// File: logic/spi_pin_sync.sv
`timescale 1ns/10ps

module spi_pin_sync #(
	parameter logic reset_value = 1'b0
) (
	input  logic clk,
	input  logic reset,
	input  logic pin,
	output logic sync_level,
	output logic rise,
	output logic fall
);

	// Bit 0 is the newest sample, bit 2 the oldest.
	logic [2:0] history;

	always_ff @(posedge clk) begin
		if (reset) begin
			history <= {3{reset_value}};
		end else begin
			history <= {history[1:0], pin};
		end
	end

	// Edges are taken between the two settled stages.
	assign rise = !history[2] && history[1];
	assign fall = history[2] && !history[1];

	assign sync_level = history[1];

endmodule

// File: logic/spi_shifter.sv
`timescale 1ns/10ps

module spi_shifter
	import spi_minion_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   cs_level,
	input  logic   cs_rise,
	input  logic   cs_fall,
	input  logic   sclk_rise,
	input  logic   sclk_fall,
	input  logic   mosi_level,
	input  frame_t pull_frame,
	output logic   miso,
	output logic   pull_en,
	output logic   push_en,
	output logic   frame_parity,
	output frame_t push_frame
);

	localparam int frame_bits = $bits(frame_t);
	localparam int data_bits = $bits(data_t);

	frame_t rx_frame;
	frame_t tx_frame;
	logic rx_shift;
	logic tx_shift;

	// A frame opens on the chip-select fall and closes on its rise.
	assign pull_en = cs_fall;
	assign push_en = cs_rise;

	// Sample on the rising serial clock, drive on the falling one.
	assign rx_shift = !cs_level && sclk_rise;
	assign tx_shift = !cs_level && sclk_fall;

	// Receive shifter, MSB first.
	// It keeps the last frame until the next one starts shifting in.
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_frame <= '0;
		end else if (rx_shift) begin
			rx_frame <= {rx_frame[frame_bits - 2:0], mosi_level};
		end
	end

	// Transmit shifter.
	// The reply loads at frame start so its MSB is on MISO before the first rise.
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_frame <= '0;
		end else if (pull_en) begin
			tx_frame <= pull_frame;
		end else if (tx_shift) begin
			tx_frame <= {tx_frame[frame_bits - 2:0], 1'b0};
		end
	end

	assign miso = tx_frame[frame_bits - 1];
	assign push_frame = rx_frame;

	// Parity over the payload of the frame just closed.
	assign frame_parity = (^push_frame[data_bits - 1:0]) && push_en;

	// Both strobes come from one synchronized chip select, so they cannot overlap.
	frame_strobes_exclusive: assert property (
		@(posedge clk) disable iff (reset) !(pull_en && push_en)
	);

endmodule

// File: verification/spi_minion_checker.sv
`timescale 1ns/10ps

`include "spi_minion_cfg.svh"

module spi_minion_checker
	import spi_minion_pkg::*;
(
	input logic  clk,
	input logic  reset,
	input logic  cs,
	input logic  sclk,
	input logic  mosi,
	input logic  miso,
	input data_t recv_msg,
	input logic  recv_val,
	input logic  recv_rdy,
	input data_t send_msg,
	input logic  send_val,
	input logic  send_rdy,
	input logic  minion_parity,
	input logic  adapter_parity
);

	localparam int frame_bits = `SPI_FRAME_BITS;
	localparam int data_bits = `SPI_DATA_BITS;
	localparam int depth = `SPI_QUEUE_DEPTH;

	// Host-to-system and system-to-host queue models.
	data_t write_model[$];
	data_t read_model[$];

	logic [2:0] cs_hist;
	logic sclk_q;
	logic reset_q = 1'b0;
	frame_t rx_bits;
	frame_t reply_bits;
	frame_t last_frame;
	frame_t expected_reply;
	int frame_count = 0;
	int check_count = 0;
	int error_count = 0;
	int test_checks = 0;
	int test_errors = 0;

	task automatic check_value(input string name, input frame_t got, input frame_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic report_test(input string name);
		$display("Test %s: %0d checks, %0d errors", name, check_count - test_checks,
			error_count - test_errors);
		test_checks = check_count;
		test_errors = error_count;
	endtask

	// Everything is sampled at the rising edge, so it sees the values from before the edge.
	always @(posedge clk) begin
		logic pull;
		logic push;
		logic write_ok;
		logic read_ok;
		logic send_pop;
		if (reset) begin
			write_model.delete();
			read_model.delete();
			cs_hist = 3'b111;
			sclk_q = 1'b0;
			last_frame = '0;
		end else begin
			// Chip select edges reach the minion two edges after they are sampled.
			pull = cs_hist[2] && !cs_hist[1];
			push = !cs_hist[2] && cs_hist[1];
			if (reset_q) begin
				check_value("send_val after reset", send_val, 0);
				check_value("miso after reset", miso, 0);
				check_value("minion_parity after reset", minion_parity, 0);
				check_value("adapter_parity after reset", adapter_parity, 0);
				check_value("recv_rdy after reset", recv_rdy, 1);
			end
			check_value("send_val", send_val, write_model.size() != 0);
			if (write_model.size() != 0) begin
				check_value("send_msg", send_msg, write_model[0]);
			end
			check_value("adapter_parity", adapter_parity,
				(write_model.size() != 0) && (^write_model[0]));
			check_value("recv_rdy", recv_rdy, read_model.size() < depth);
			check_value("minion_parity", minion_parity, push && (^last_frame[data_bits - 1:0]));

			write_ok = write_model.size() < depth;
			read_ok = read_model.size() < depth;
			send_pop = send_rdy && (write_model.size() != 0);

			// Reply is {valid, space, data}.
			if (pull) begin
				expected_reply = '0;
				expected_reply[frame_bits - 2] = write_ok;
				if (last_frame[frame_bits - 2] && (read_model.size() != 0)) begin
					expected_reply[frame_bits - 1] = 1'b1;
					expected_reply[data_bits - 1:0] = read_model[0];
					read_model.delete(0);
				end
			end
			if (send_pop) begin
				write_model.delete(0);
			end
			if (recv_val && read_ok) begin
				read_model.push_back(recv_msg);
			end
			if (push && last_frame[frame_bits - 1] && write_ok) begin
				write_model.push_back(last_frame[data_bits - 1:0]);
			end

			// Serial side, rebuilt from the raw pins.
			if (!cs && sclk && !sclk_q) begin
				rx_bits = {rx_bits[frame_bits - 2:0], mosi};
				reply_bits = {reply_bits[frame_bits - 2:0], miso};
			end
			if (cs && !cs_hist[0]) begin
				frame_count++;
				check_value("miso reply", reply_bits, expected_reply);
				last_frame = rx_bits;
			end
			sclk_q = sclk;
			cs_hist = {cs_hist[1:0], cs};
		end
		reset_q = reset;
	end

endmodule

// File: verification/spi_minion_tb.sv
`timescale 1ns/10ps

`include "spi_minion_cfg.svh"

module spi_minion_tb
	import spi_minion_pkg::*;
();

	localparam int clk_period = 4;
	localparam int phase = 4;
	localparam int depth = `SPI_QUEUE_DEPTH;
	localparam int frame_bits = `SPI_FRAME_BITS;
	localparam int random_frames = 24;
	localparam int total_frames = random_frames + 2 * depth + 6;
	// Select setup, two phases per bit, then the hold and the idle gap.
	localparam int frame_cycles = phase * (2 * frame_bits + 4);
	localparam int watchdog_cycles = total_frames * frame_cycles + 1000;

	localparam int mode_idle = 0;
	localparam int mode_random = 1;
	localparam int mode_drain = 2;

	logic clk = 1'b0;
	logic reset;
	logic cs;
	logic sclk;
	logic mosi;
	data_t recv_msg;
	logic recv_val;
	logic send_rdy;
	logic miso;
	logic recv_rdy;
	logic send_val;
	logic minion_parity;
	logic adapter_parity;
	data_t send_msg;

	integer seed = 51142;
	int sys_mode;
	logic recv_taken;

	always #(clk_period / 2) clk = !clk;

	spi_minion spi_minion_i (.*);

	spi_minion_checker check_i (.*);

	always @(posedge clk) begin
		recv_taken <= recv_val && recv_rdy;
	end

	// A pending system word stays on the bus until it is taken.
	task automatic drive_system();
		if (!recv_val || recv_taken) begin
			if (sys_mode == mode_random) begin
				recv_val = ($random(seed) & 7) == 0;
				recv_msg = $random(seed);
			end else begin
				recv_val = 1'b0;
			end
		end
		send_rdy = (sys_mode == mode_drain) || ((sys_mode == mode_random) && ($random(seed) & 1));
	endtask

	task automatic next_cycle();
		@(negedge clk);
		drive_system();
	endtask

	// One SPI frame, MSB first, each serial clock phase held for four cycles.
	task automatic spi_frame(input logic write, input logic read, input data_t data);
		frame_t frame;
		int b;
		frame = {write, read, data};
		next_cycle();
		cs = 1'b0;
		for (b = frame_bits - 1; b >= 0; b--) begin
			mosi = frame[b];
			repeat (phase) next_cycle();
			sclk = 1'b1;
			repeat (phase) next_cycle();
			sclk = 1'b0;
		end
		repeat (phase) next_cycle();
		cs = 1'b1;
		repeat (2 * phase) next_cycle();
	endtask

	initial begin
		int i;
		data_t word;
		logic [1:0] flags;
		cs = 1'b1;
		sclk = 1'b0;
		mosi = 1'b0;
		recv_msg = '0;
		recv_val = 1'b0;
		send_rdy = 1'b0;
		sys_mode = mode_idle;
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		repeat (4) next_cycle();
		check_i.report_test("reset");

		sys_mode = mode_random;
		for (i = 0; i < random_frames; i++) begin
			word = $random(seed);
			flags = $random(seed);
			spi_frame(flags[1], flags[0], word);
		end
		check_i.report_test("random traffic");

		// No draining, so the write queue fills and later writes are lost.
		sys_mode = mode_idle;
		for (i = 0; i < depth + 3; i++) begin
			word = $random(seed);
			spi_frame(1'b1, 1'b0, word);
		end
		check_i.report_test("write queue full");

		// One read more than the read queue and a pending word can supply.
		sys_mode = mode_drain;
		for (i = 0; i < depth + 3; i++) begin
			spi_frame(1'b0, 1'b1, '0);
		end
		while (send_val) begin
			next_cycle();
		end
		check_i.report_test("drain");

		repeat (8) next_cycle();
		$display("%0d frames, %0d checks, %0d errors", check_i.frame_count,
			check_i.check_count, check_i.error_count);
		if (check_i.error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Watchdog sized from the frame count.
	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout after %0d cycles, the test sequence did not finish", watchdog_cycles);
		$display("Checks failed");
		$finish;
	end

endmodule
